/* lru_cmd_pkg.sv */
`default_nettype none

package lru_cmd_pkg;

    localparam int OP_W = 2;

    // opcodes keep the legacy controller encoding
    typedef enum logic [OP_W-1:0] {
        CMD_WRITE  = 2'b00,
        CMD_LOOKUP = 2'b01,
        CMD_ALLOC  = 2'b10,
        CMD_FILL   = 2'b11
    } cmd_op_e;

    // request word field positions
    localparam int REQ_OP_LSB    = 0;
    localparam int REQ_INDEX_LSB = 8;
    localparam int REQ_TAG_LSB   = 16;

    // response word field positions
    localparam int RSP_HIT_BIT    = 0;
    localparam int RSP_STATUS_LSB = 4;
    localparam int RSP_TAG_LSB    = 8;
    localparam int RSP_INDEX_LSB  = 16;

endpackage

`default_nettype wire

/* lru_line_pkg.sv */
`default_nettype none

package lru_line_pkg;

    localparam int STATUS_W = 2;

    // valid and dirty keep their old low bits, fetch takes the spare code
    typedef enum logic [STATUS_W-1:0] {
        LINE_INVALID = 2'b00,
        LINE_VALID   = 2'b01,
        LINE_DIRTY   = 2'b10,
        LINE_FETCH   = 2'b11
    } line_status_e;

endpackage

`default_nettype wire

/* wb_cmd_slave.sv */
`default_nettype none
`timescale 1ns/1ps

module wb_cmd_slave
    import lru_cmd_pkg::*;
    import lru_line_pkg::*;
#(
    parameter int LINES   = 8,
    parameter int INDEX_W = 6,
    localparam int TAG_W  = $clog2(LINES)
) (
    input  logic               clk,
    input  logic               rst_n,

    input  logic               wb_cyc,
    input  logic               wb_stb,
    input  logic               wb_we,
    input  logic [31:0]        wb_dat_w,
    output logic [31:0]        wb_dat_r,
    output logic               wb_ack,

    input  logic               hit,
    input  line_status_e       resp_status,
    input  logic [INDEX_W-1:0] resp_index,
    input  logic [TAG_W-1:0]   resp_tag,

    output logic               op_valid,
    output cmd_op_e            op,
    output logic [INDEX_W-1:0] req_index,
    output logic [TAG_W-1:0]   fill_tag
);

    logic        accept;
    logic        rsp_hit;
    logic [31:0] rsp_word;

    // stb is ignored during the ack cycle
    assign accept   = wb_cyc && wb_stb && !wb_ack;
    // reads are acked and report, but change no state
    assign op_valid = accept && wb_we;

    assign op        = cmd_op_e'(wb_dat_w[REQ_OP_LSB +: OP_W]);
    assign req_index = wb_dat_w[REQ_INDEX_LSB +: INDEX_W];
    assign fill_tag  = wb_dat_w[REQ_TAG_LSB +: TAG_W];

    always_comb begin
        case (op)
            CMD_LOOKUP, CMD_WRITE: rsp_hit = hit;
            // a fill lands only on a line that was fetching
            CMD_FILL:              rsp_hit = (resp_status == LINE_FETCH);
            default:               rsp_hit = 1'b0;
        endcase
    end

    always_comb begin
        rsp_word                                 = '0;
        rsp_word[RSP_HIT_BIT]                    = rsp_hit;
        rsp_word[RSP_STATUS_LSB +: STATUS_W]     = resp_status;
        rsp_word[RSP_TAG_LSB +: TAG_W]           = resp_tag;
        rsp_word[RSP_INDEX_LSB +: INDEX_W]       = resp_index;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wb_ack   <= 1'b0;
            wb_dat_r <= '0;
        end else begin
            wb_ack <= accept;
            if (accept) begin
                wb_dat_r <= rsp_word;
            end
        end
    end

endmodule

`default_nettype wire

/* tag_lookup.sv */
`default_nettype none
`timescale 1ns/1ps

module tag_lookup #(
    parameter int LINES   = 8,
    parameter int INDEX_W = 6,
    localparam int TAG_W  = $clog2(LINES)
) (
    input  logic [INDEX_W-1:0]       req_index,
    input  logic [LINES-1:0]         line_live,
    input  logic [LINES*INDEX_W-1:0] line_index,
    output logic                     hit,
    output logic [TAG_W-1:0]         hit_tag
);

    // fully associative search, last match in loop order wins
    always_comb begin
        hit     = 1'b0;
        hit_tag = '0;
        for (int i = 0; i < LINES; i++) begin
            if (line_live[i] && line_index[i*INDEX_W +: INDEX_W] == req_index) begin
                hit     = 1'b1;
                hit_tag = TAG_W'(i);
            end
        end
    end

endmodule

`default_nettype wire

/* tag_status_table.sv */
`default_nettype none
`timescale 1ns/1ps

module tag_status_table
    import lru_cmd_pkg::*;
    import lru_line_pkg::*;
#(
    parameter int LINES   = 8,
    parameter int INDEX_W = 6,
    localparam int TAG_W  = $clog2(LINES)
) (
    input  logic                     clk,
    input  logic                     rst_n,

    input  logic                     op_valid,
    input  cmd_op_e                  op,
    input  logic [INDEX_W-1:0]       req_index,
    input  logic [TAG_W-1:0]         fill_tag,
    input  logic                     hit,
    input  logic [TAG_W-1:0]         hit_tag,
    input  logic [TAG_W-1:0]         alloc_tag,

    output logic [LINES-1:0]         line_live,
    output logic [LINES*INDEX_W-1:0] line_index,
    output line_status_e             resp_status,
    output logic [INDEX_W-1:0]       resp_index,
    output logic [TAG_W-1:0]         resp_tag
);

    line_status_e       status_q [LINES];
    logic [INDEX_W-1:0] index_q  [LINES];

    for (genvar g = 0; g < LINES; g++) begin : g_line
        assign line_live[g]                       = (status_q[g] != LINE_INVALID);
        assign line_index[g*INDEX_W +: INDEX_W]   = index_q[g];
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < LINES; i++) begin
                status_q[i] <= LINE_INVALID;
                index_q[i]  <= '0;
            end
        end else if (op_valid) begin
            case (op)
                CMD_WRITE: begin
                    if (hit) begin
                        status_q[hit_tag] <= LINE_DIRTY;
                    end
                end
                CMD_ALLOC: begin
                    status_q[alloc_tag] <= LINE_FETCH;
                    index_q[alloc_tag]  <= req_index;
                end
                CMD_FILL: begin
                    if (status_q[fill_tag] == LINE_FETCH) begin
                        status_q[fill_tag] <= LINE_VALID;
                    end
                end
                default: ;
            endcase
        end
    end

    // reports the line as it was before this command
    always_comb begin
        resp_status = LINE_INVALID;
        resp_index  = '0;
        resp_tag    = '0;
        case (op)
            CMD_LOOKUP, CMD_WRITE: begin
                if (hit) begin
                    resp_tag    = hit_tag;
                    resp_status = status_q[hit_tag];
                    resp_index  = index_q[hit_tag];
                end
            end
            // victim's old status and index, for write-back
            CMD_ALLOC: begin
                resp_tag    = alloc_tag;
                resp_status = status_q[alloc_tag];
                resp_index  = index_q[alloc_tag];
            end
            CMD_FILL: begin
                resp_tag    = fill_tag;
                resp_status = status_q[fill_tag];
            end
            default: ;
        endcase
    end

endmodule

`default_nettype wire

/* lru_list_ctrl.sv */
`default_nettype none
`timescale 1ns/1ps

module lru_list_ctrl
    import lru_cmd_pkg::*;
#(
    parameter int LINES  = 8,
    localparam int TAG_W = $clog2(LINES)
) (
    input  logic             clk,
    input  logic             rst_n,

    input  logic             op_valid,
    input  cmd_op_e          op,
    input  logic             hit,
    input  logic [TAG_W-1:0] hit_tag,

    output logic [TAG_W-1:0] alloc_tag
);

    // free list, allocation pops its tail
    logic [TAG_W-1:0] free_tail;
    logic [TAG_W:0]   free_len;
    logic             free_empty;

    // recency list, head is most recent
    logic [TAG_W-1:0] rec_head;
    logic [TAG_W-1:0] rec_tail;
    logic [TAG_W:0]   rec_len;
    logic             rec_empty;

    // links shared by both lists, a line is on exactly one of them
    logic [TAG_W-1:0] prev_tag [LINES];
    logic [TAG_W-1:0] next_tag [LINES];

    logic             do_touch;
    logic             do_take;
    logic             do_evict;
    logic             do_move;
    logic [TAG_W-1:0] move_tag;
    logic [TAG_W-1:0] move_prev;
    logic [TAG_W-1:0] move_next;

    assign free_empty = (free_len == '0);
    assign rec_empty  = (rec_len == '0);

    assign alloc_tag = free_empty ? rec_tail : free_tail;

    assign do_touch = op_valid && hit && (op == CMD_LOOKUP || op == CMD_WRITE);
    assign do_take  = op_valid && (op == CMD_ALLOC) && !free_empty;
    assign do_evict = op_valid && (op == CMD_ALLOC) && free_empty;

    // eviction is a move-to-head of the recency tail
    assign do_move   = do_touch || do_evict;
    assign move_tag  = do_evict ? rec_tail : hit_tag;
    assign move_prev = prev_tag[move_tag];
    assign move_next = next_tag[move_tag];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            free_tail <= TAG_W'(LINES - 1);
            free_len  <= (TAG_W + 1)'(LINES);
            rec_head  <= '0;
            rec_tail  <= '0;
            rec_len   <= '0;
            // free list 0 .. LINES-1 in order
            for (int i = 0; i < LINES; i++) begin
                prev_tag[i] <= TAG_W'((i + LINES - 1) % LINES);
                next_tag[i] <= TAG_W'((i + 1) % LINES);
            end
        end else if (do_take) begin
            free_tail <= prev_tag[free_tail];
            free_len  <= free_len - 1'b1;
            rec_len   <= rec_len + 1'b1;
            rec_head  <= free_tail;
            if (rec_empty) begin
                rec_tail <= free_tail;
            end else begin
                next_tag[free_tail] <= rec_head;
                prev_tag[rec_head]  <= free_tail;
            end
        end else if (do_move && move_tag != rec_head) begin
            // unlink, not the head so a predecessor exists
            next_tag[move_prev] <= move_next;
            if (move_tag == rec_tail) begin
                rec_tail <= move_prev;
            end else begin
                prev_tag[move_next] <= move_prev;
            end
            // relink in front of the old head
            next_tag[move_tag] <= rec_head;
            prev_tag[rec_head] <= move_tag;
            rec_head           <= move_tag;
        end
    end

endmodule

`default_nettype wire

/* lru_top.sv */
`default_nettype none
`timescale 1ns/1ps

module lru_top
    import lru_cmd_pkg::*;
    import lru_line_pkg::*;
#(
    parameter int LINES   = 8,
    parameter int INDEX_W = 6
) (
    input  logic        clk,
    input  logic        rst_n,

    input  logic        wb_cyc,
    input  logic        wb_stb,
    input  logic        wb_we,
    input  logic [31:0] wb_dat_w,
    output logic [31:0] wb_dat_r,
    output logic        wb_ack
);

    localparam int TAG_W = $clog2(LINES);

    logic                     op_valid;
    cmd_op_e                  op;
    logic [INDEX_W-1:0]       req_index;
    logic [TAG_W-1:0]         fill_tag;

    logic                     hit;
    logic [TAG_W-1:0]         hit_tag;
    logic [TAG_W-1:0]         alloc_tag;

    logic [LINES-1:0]         line_live;
    logic [LINES*INDEX_W-1:0] line_index;
    line_status_e             resp_status;
    logic [INDEX_W-1:0]       resp_index;
    logic [TAG_W-1:0]         resp_tag;

    wb_cmd_slave #(
        .LINES   (LINES),
        .INDEX_W (INDEX_W)
    ) u_slave (
        .clk         (clk),
        .rst_n       (rst_n),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack),
        .hit         (hit),
        .resp_status (resp_status),
        .resp_index  (resp_index),
        .resp_tag    (resp_tag),
        .op_valid    (op_valid),
        .op          (op),
        .req_index   (req_index),
        .fill_tag    (fill_tag)
    );

    tag_lookup #(
        .LINES   (LINES),
        .INDEX_W (INDEX_W)
    ) u_lookup (
        .req_index  (req_index),
        .line_live  (line_live),
        .line_index (line_index),
        .hit        (hit),
        .hit_tag    (hit_tag)
    );

    tag_status_table #(
        .LINES   (LINES),
        .INDEX_W (INDEX_W)
    ) u_table (
        .clk         (clk),
        .rst_n       (rst_n),
        .op_valid    (op_valid),
        .op          (op),
        .req_index   (req_index),
        .fill_tag    (fill_tag),
        .hit         (hit),
        .hit_tag     (hit_tag),
        .alloc_tag   (alloc_tag),
        .line_live   (line_live),
        .line_index  (line_index),
        .resp_status (resp_status),
        .resp_index  (resp_index),
        .resp_tag    (resp_tag)
    );

    lru_list_ctrl #(
        .LINES (LINES)
    ) u_lists (
        .clk       (clk),
        .rst_n     (rst_n),
        .op_valid  (op_valid),
        .op        (op),
        .hit       (hit),
        .hit_tag   (hit_tag),
        .alloc_tag (alloc_tag)
    );

endmodule

`default_nettype wire

/* tb_lru_model.svh */
`ifndef TB_LRU_MODEL_SVH
`define TB_LRU_MODEL_SVH

// line table plus both lists kept as tag queues
line_status_e       m_status [LINES];
logic [INDEX_W-1:0] m_index  [LINES];
int                 free_q [$];
// entry 0 is the most recently used line
int                 rec_q [$];

task automatic reset_model();
    free_q.delete();
    rec_q.delete();
    for (int i = 0; i < LINES; i++) begin
        m_status[i] = LINE_INVALID;
        m_index[i]  = '0;
        free_q.push_back(i);
    end
endtask

// highest live line with a matching index
task automatic find_line(input logic [INDEX_W-1:0] idx, output logic hit, output int tag);
    hit = 1'b0;
    tag = 0;
    for (int i = 0; i < LINES; i++) begin
        if (m_status[i] != LINE_INVALID && m_index[i] == idx) begin
            hit = 1'b1;
            tag = i;
        end
    end
endtask

task automatic move_to_head(input int tag);
    for (int i = 0; i < rec_q.size(); i++) begin
        if (rec_q[i] == tag) begin
            rec_q.delete(i);
            break;
        end
    end
    rec_q.push_front(tag);
endtask

function automatic logic [31:0] pack_response(input logic hit, input line_status_e st,
                                              input int tag, input logic [INDEX_W-1:0] idx);
    logic [31:0] w;
    w                             = '0;
    w[RSP_HIT_BIT]                = hit;
    w[RSP_STATUS_LSB +: STATUS_W] = st;
    w[RSP_TAG_LSB +: TAG_W]       = TAG_W'(tag);
    w[RSP_INDEX_LSB +: INDEX_W]   = idx;
    return w;
endfunction

// expected response from the old state, then the model update
task automatic predict_response(input cmd_op_e op, input logic [INDEX_W-1:0] idx,
                                input logic [TAG_W-1:0] ftag, output logic [31:0] exp_word);
    logic hit;
    int   tag;
    find_line(idx, hit, tag);
    exp_word = '0;
    case (op)
        CMD_LOOKUP, CMD_WRITE: begin
            if (hit) begin
                exp_word = pack_response(1'b1, m_status[tag], tag, m_index[tag]);
                if (op == CMD_WRITE) begin
                    m_status[tag] = LINE_DIRTY;
                end
                move_to_head(tag);
            end
        end
        CMD_ALLOC: begin
            // free tail first, else the least recent line
            if (free_q.size() > 0) begin
                tag = free_q.pop_back();
            end else begin
                tag = rec_q[rec_q.size() - 1];
            end
            exp_word      = pack_response(1'b0, m_status[tag], tag, m_index[tag]);
            m_status[tag] = LINE_FETCH;
            m_index[tag]  = idx;
            move_to_head(tag);
        end
        CMD_FILL: begin
            exp_word = pack_response(m_status[ftag] == LINE_FETCH, m_status[ftag], ftag, '0);
            if (m_status[ftag] == LINE_FETCH) begin
                m_status[ftag] = LINE_VALID;
            end
        end
        default: ;
    endcase
endtask

`endif

/* tb_lru_top.sv */
`default_nettype none
`timescale 1ns/1ps

module tb_lru_top
    import lru_cmd_pkg::*;
    import lru_line_pkg::*;
();

    localparam int LINES       = 8;
    localparam int INDEX_W     = 6;
    localparam int TAG_W       = $clog2(LINES);
    localparam int CLK_PERIOD  = 4;
    localparam int ACK_LIMIT   = 8;
    localparam int LOOKUP_CMDS = 40;
    localparam int MIX_CMDS    = 300;
    // write_dirty and fill_rule add six commands
    localparam int CMD_COUNT   = LINES + LOOKUP_CMDS + 6 + MIX_CMDS;

    logic        clk;
    logic        rst_n;
    logic        wb_cyc;
    logic        wb_stb;
    logic        wb_we;
    logic [31:0] wb_dat_w;
    logic [31:0] wb_dat_r;
    logic        wb_ack;

    logic [31:0] lfsr_state;
    int          errors;
    int          test_errors;
    int          checks;
    int          tests_run;

    `include "tb_lru_model.svh"

    lru_top #(
        .LINES   (LINES),
        .INDEX_W (INDEX_W)
    ) u_dut (
        .clk      (clk),
        .rst_n    (rst_n),
        .wb_cyc   (wb_cyc),
        .wb_stb   (wb_stb),
        .wb_we    (wb_we),
        .wb_dat_w (wb_dat_w),
        .wb_dat_r (wb_dat_r),
        .wb_ack   (wb_ack)
    );

    initial begin
        clk = 1'b0;
        forever begin
            #(CLK_PERIOD / 2) clk = ~clk;
        end
    end

    initial begin
        #((CMD_COUNT * 10 + 100) * CLK_PERIOD);
        $display("timeout, the tests did not finish in time");
        $display("sim failed");
        $finish;
    end

    // galois taps for x^32 + x^22 + x^2 + x + 1
    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
    endfunction

    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] v;
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v          = {v[30:0], lfsr_state[0]};
        end
        return v;
    endfunction

    task automatic check_value(input string name, input logic [31:0] exp,
                               input logic [31:0] act);
        checks++;
        if (act !== exp) begin
            $display("Error %s: expected %h, actual %h", name, exp, act);
            errors++;
            test_errors++;
        end
    endtask

    task automatic end_test(input string name);
        if (test_errors == 0) begin
            $display("test %s: ok", name);
        end else begin
            $display("test %s: %0d errors", name, test_errors);
        end
        tests_run++;
        test_errors = 0;
    endtask

    // one Wishbone write checked against the model
    task automatic run_command(input string name, input cmd_op_e op,
                               input logic [INDEX_W-1:0] idx, input logic [TAG_W-1:0] ftag,
                               output logic [31:0] rsp);
        logic [31:0] exp_word;
        logic [31:0] req;
        int          waited;
        predict_response(op, idx, ftag, exp_word);
        req                           = '0;
        req[REQ_OP_LSB +: OP_W]       = op;
        req[REQ_INDEX_LSB +: INDEX_W] = idx;
        req[REQ_TAG_LSB +: TAG_W]     = ftag;
        @(negedge clk);
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = 1'b1;
        wb_dat_w = req;
        waited   = 0;
        do begin
            @(negedge clk);
            waited++;
        end while (!wb_ack && waited < ACK_LIMIT);
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        rsp    = wb_dat_r;
        if (!wb_ack) begin
            $display("%s: no ack within %0d cycles", name, ACK_LIMIT);
            errors++;
            test_errors++;
        end else begin
            check_value(name, exp_word, rsp);
        end
    endtask

    task automatic pick_missing_index(output logic [INDEX_W-1:0] idx);
        logic hit;
        int   tag;
        do begin
            idx = INDEX_W'(rand_bits(INDEX_W));
            find_line(idx, hit, tag);
        end while (hit);
    endtask

    // about half the time an index that is cached
    task automatic pick_any_index(output logic [INDEX_W-1:0] idx);
        if (rec_q.size() > 0 && rand_bits(1) == 1) begin
            idx = m_index[rec_q[rand_bits(TAG_W) % rec_q.size()]];
        end else begin
            idx = INDEX_W'(rand_bits(INDEX_W));
        end
    endtask

    initial begin
        logic [INDEX_W-1:0] idx;
        logic [31:0]        rsp;
        int                 tag;
        cmd_op_e            op;
        rst_n       = 1'b0;
        wb_cyc      = 1'b0;
        wb_stb      = 1'b0;
        wb_we       = 1'b0;
        wb_dat_w    = '0;
        lfsr_state  = 32'h4820_8eac;
        errors      = 0;
        test_errors = 0;
        checks      = 0;
        tests_run   = 0;
        reset_model();
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst_n = 1'b1;

        // bus outputs come out of reset idle
        check_value("reset_state ack", 0, wb_ack);
        check_value("reset_state dat_r", 0, wb_dat_r);
        end_test("reset_state");

        // free list hands out lines from the top down
        for (int i = 0; i < LINES; i++) begin
            pick_missing_index(idx);
            run_command("free_alloc", CMD_ALLOC, idx, '0, rsp);
            check_value("free_alloc tag", LINES - 1 - i, rsp[RSP_TAG_LSB +: TAG_W]);
            check_value("free_alloc status", LINE_INVALID, rsp[RSP_STATUS_LSB +: STATUS_W]);
        end
        end_test("free_alloc");

        for (int i = 0; i < LOOKUP_CMDS; i++) begin
            pick_any_index(idx);
            run_command("lookup_mix", CMD_LOOKUP, idx, '0, rsp);
        end
        end_test("lookup_mix");

        tag = rec_q[rec_q.size() - 1];
        run_command("write_dirty", CMD_WRITE, m_index[tag], '0, rsp);
        run_command("write_dirty", CMD_LOOKUP, m_index[tag], '0, rsp);
        check_value("write_dirty status", LINE_DIRTY, rsp[RSP_STATUS_LSB +: STATUS_W]);
        end_test("write_dirty");

        for (int i = 0; i < LINES; i++) begin
            if (m_status[i] == LINE_FETCH) begin
                tag = i;
            end
        end
        run_command("fill_rule", CMD_FILL, '0, TAG_W'(tag), rsp);
        check_value("fill_rule hit", 1, rsp[RSP_HIT_BIT]);
        run_command("fill_rule", CMD_LOOKUP, m_index[tag], '0, rsp);
        check_value("fill_rule valid", LINE_VALID, rsp[RSP_STATUS_LSB +: STATUS_W]);
        // second fill finds the line valid and leaves it
        run_command("fill_rule", CMD_FILL, '0, TAG_W'(tag), rsp);
        check_value("fill_rule refill hit", 0, rsp[RSP_HIT_BIT]);
        run_command("fill_rule", CMD_LOOKUP, m_index[tag], '0, rsp);
        check_value("fill_rule still valid", LINE_VALID, rsp[RSP_STATUS_LSB +: STATUS_W]);
        end_test("fill_rule");

        // all lines in use so every alloc evicts
        for (int i = 0; i < MIX_CMDS; i++) begin
            op = cmd_op_e'(rand_bits(OP_W));
            if (op == CMD_ALLOC) begin
                pick_missing_index(idx);
            end else begin
                pick_any_index(idx);
            end
            run_command("random_mix", op, idx, TAG_W'(rand_bits(TAG_W)), rsp);
        end
        end_test("random_mix");

        $display("tests %0d, checks %0d, errors %0d", tests_run, checks, errors);
        if (errors == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* filelist.f */
+incdir+.
lru_cmd_pkg.sv
lru_line_pkg.sv
wb_cmd_slave.sv
tag_lookup.sv
tag_status_table.sv
lru_list_ctrl.sv
lru_top.sv
tb_lru_top.sv

/* Bender.yml */
package:
  name: lru_cache_ctrl

sources:
  - lru_cmd_pkg.sv
  - lru_line_pkg.sv
  - wb_cmd_slave.sv
  - tag_lookup.sv
  - tag_status_table.sv
  - lru_list_ctrl.sv
  - lru_top.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_lru_top.sv
